//--- daq_core.f
verilog/daq_pkg.sv
verilog/bus_decoder.sv
verilog/system_regs.sv
verilog/board_control.sv
verilog/pulse_regs.sv
verilog/pulse_core.sv
verilog/readout_arbiter.sv
verilog/daq_core.sv
testbench/tb_daq_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the daq_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f daq_core.f --top-module tb_daq_core \
    -Mdir "$BUILD_DIR" -o tb_daq_core
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_daq_core" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
    echo "run_sim: failures found in $LOG_FILE"
    exit 1
fi
echo "run_sim: done"
exit 0

//--- testbench/tb_daq_core.sv
module tb_daq_core;

    localparam logic [31:0] LFSR_SEED = 32'hba6d_7e6d;
    // A few hundred cycles are needed, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int N = daq_pkg::N_STREAMS;
    localparam int SW = daq_pkg::STREAM_WIDTH;

    localparam logic [15:0] SYS = daq_pkg::SYS_BASEADDR;
    localparam logic [15:0] CTRL = daq_pkg::CTRL_BASEADDR;
    localparam logic [15:0] PULSE = daq_pkg::PULSE_RST_BASEADDR;
    localparam logic [15:0] SYS_CLK_FLAG = 16'd4;
    localparam logic [15:0] SYS_CLK_SET = 16'd5;
    localparam logic [15:0] CTRL_HOLD = 16'd2;
    localparam logic [15:0] PULSE_SOFT_RST = 16'd0;
    localparam logic [15:0] PULSE_START = 16'd1;
    localparam logic [15:0] PULSE_DONE = 16'd2;
    localparam logic [15:0] PULSE_DELAY = 16'd3;
    localparam logic [15:0] PULSE_WIDTH = 16'd4;

    logic          bus_clk = 1'b0;
    logic          bus_rst = 1'b1;
    logic [15:0]   i_bus_add = '0;
    logic [7:0]    i_bus_data = '0;
    logic          i_bus_rd = 1'b0;
    logic          i_bus_wr = 1'b0;
    logic [7:0]    o_bus_data;
    logic [3:0]    i_gpio_sense = '0;
    logic [7:0]    o_lemo_mux;
    logic [2:0]    o_ntc_mux;
    logic          o_mgt_ref_sel;
    logic          o_resetb_ext;
    logic [N-1:0]  i_stream_valid = '0;
    logic [N*SW-1:0] i_stream_data = '0;
    logic [N-1:0]  o_stream_read;
    logic          i_arb_ready = 1'b0;
    logic          o_arb_write;
    logic [SW-1:0] o_arb_data;

    logic [31:0]   lfsr_state = LFSR_SEED;
    int            cycle_count = 0;
    int            error_count = 0;
    int            errors_at_test_start = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    // Expected state, tracked from the bus traffic
    logic [15:0]   ctrl_exp;
    logic          hold_exp;
    logic          pulse_armed;
    int            pulse_age;
    int            pulse_delay_exp = 0;
    int            pulse_width_exp = 0;
    logic          pulse_on_exp;
    logic          pulse_done_exp;
    logic          resetb_exp;
    int            arb_last;
    int            exp_sel;
    logic          exp_write;
    logic [N-1:0]  exp_grant;
    logic [SW-1:0] exp_data;

    daq_core daq_core_i (
        .i_bus_clk(bus_clk), .i_bus_rst(bus_rst), .i_bus_add(i_bus_add),
        .i_bus_data(i_bus_data), .i_bus_rd(i_bus_rd), .i_bus_wr(i_bus_wr),
        .o_bus_data(o_bus_data), .i_gpio_sense(i_gpio_sense), .o_lemo_mux(o_lemo_mux),
        .o_ntc_mux(o_ntc_mux), .o_mgt_ref_sel(o_mgt_ref_sel), .o_resetb_ext(o_resetb_ext),
        .i_stream_valid(i_stream_valid), .i_stream_data(i_stream_data),
        .o_stream_read(o_stream_read), .i_arb_ready(i_arb_ready),
        .o_arb_write(o_arb_write), .o_arb_data(o_arb_data)
    );

    always #10 bus_clk = ~bus_clk;

    always @(posedge bus_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Scan backwards so the earliest stream in rotation order wins
    function automatic int first_valid_after(input int last, input logic [N-1:0] valid);
        int cand;
        int result;
        result = -1;
        for (int d = N; d >= 1; d--) begin
            cand = (last + d) % N;
            if (valid[cand]) result = cand;
        end
        return result;
    endfunction

    always @(posedge bus_clk) begin
        if (bus_rst) begin
            ctrl_exp <= '0;
            hold_exp <= 1'b0;
            pulse_armed <= 1'b0;
            pulse_age <= 0;
            arb_last <= N - 1;
        end else begin
            if (pulse_armed) pulse_age <= pulse_age + 1;
            if (i_bus_wr) begin
                case (i_bus_add)
                    CTRL: ctrl_exp[7:0] <= i_bus_data;
                    CTRL + 16'd1: ctrl_exp[15:8] <= i_bus_data;
                    CTRL + CTRL_HOLD: hold_exp <= i_bus_data[0];
                    PULSE + PULSE_SOFT_RST: pulse_armed <= 1'b0;
                    PULSE + PULSE_START: begin
                        pulse_armed <= 1'b1;
                        pulse_age <= 1;
                    end
                    default: begin
                    end
                endcase
            end
            if (exp_write) arb_last <= exp_sel;
        end
    end

    assign pulse_on_exp = pulse_armed && pulse_age > pulse_delay_exp
                          && pulse_age <= pulse_delay_exp + pulse_width_exp;
    assign pulse_done_exp = pulse_armed && pulse_age > pulse_delay_exp + pulse_width_exp;
    assign resetb_exp = !(pulse_on_exp || hold_exp);

    always_comb begin
        exp_sel = first_valid_after(arb_last, i_stream_valid);
        exp_write = i_arb_ready && exp_sel >= 0;
        exp_grant = '0;
        exp_data = '0;
        if (exp_write) begin
            exp_grant[exp_sel] = 1'b1;
            exp_data = i_stream_data[exp_sel*SW +: SW];
        end
    end

    assert property (@(posedge bus_clk) disable iff (bus_rst) o_resetb_ext == resetb_exp)
        else begin
            $display("[FAIL] o_resetb_ext: got 0x%h expected 0x%h", o_resetb_ext, resetb_exp);
            error_count++;
        end

    assert property (@(posedge bus_clk) disable iff (bus_rst)
        o_lemo_mux == ctrl_exp[14:7] && o_ntc_mux == ctrl_exp[6:4])
        else begin
            $display("[FAIL] o_lemo_mux/o_ntc_mux: got 0x%h/0x%h expected 0x%h/0x%h",
                     o_lemo_mux, o_ntc_mux, ctrl_exp[14:7], ctrl_exp[6:4]);
            error_count++;
        end

    assert property (@(posedge bus_clk) disable iff (bus_rst) o_mgt_ref_sel == !ctrl_exp[15])
        else begin
            $display("[FAIL] o_mgt_ref_sel: got 0x%h expected 0x%h", o_mgt_ref_sel, !ctrl_exp[15]);
            error_count++;
        end

    assert property (@(posedge bus_clk) disable iff (bus_rst)
        o_arb_write == exp_write && o_stream_read == exp_grant)
        else begin
            $display("[FAIL] o_arb_write/o_stream_read: got 0x%h/0x%h expected 0x%h/0x%h",
                     o_arb_write, o_stream_read, exp_write, exp_grant);
            error_count++;
        end

    assert property (@(posedge bus_clk) disable iff (bus_rst) exp_write |-> o_arb_data == exp_data)
        else begin
            $display("[FAIL] o_arb_data: got 0x%h expected 0x%h", o_arb_data, exp_data);
            error_count++;
        end

    // All bus tasks start and end 2 time units after a rising edge
    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge bus_clk);
            #2;
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        i_bus_add = addr;
        i_bus_data = data;
        i_bus_wr = 1'b1;
        next_cycles(1);
        i_bus_wr = 1'b0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp, input string what);
        i_bus_add = addr;
        i_bus_rd = 1'b1;
        next_cycles(1);
        i_bus_rd = 1'b0;
        @(negedge bus_clk);
        if (o_bus_data !== exp) begin
            $display("[FAIL] o_bus_data (%s): got 0x%h expected 0x%h", what, o_bus_data, exp);
            error_count++;
        end
        next_cycles(1);
    endtask

    task automatic drive_streams(input logic [N-1:0] valid);
        logic [31:0] word;
        i_stream_valid = valid;
        for (int s = 0; s < N; s++) begin
            draw_bits(SW, word);
            i_stream_data[s*SW +: SW] = word;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == errors_at_test_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     error_count - errors_at_test_start);
        end
        errors_at_test_start = error_count;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        repeat (8) @(posedge bus_clk);
        #2;
        bus_rst = 1'b0;
        next_cycles(2);

        read_expect(SYS, daq_pkg::VERSION, "version");
        read_expect(SYS + 16'd1, daq_pkg::VERSION_MINOR, "version minor");
        read_expect(SYS + 16'd2, daq_pkg::VERSION_MAJOR, "version major");
        read_expect(SYS + 16'd3, daq_pkg::BOARD_ID, "board id");
        write_reg(SYS + SYS_CLK_SET, 8'h01);
        read_expect(SYS + SYS_CLK_FLAG, 8'h01, "clock flag set");
        write_reg(SYS + SYS_CLK_SET, 8'h00);
        read_expect(SYS + SYS_CLK_FLAG, 8'h00, "clock flag cleared");
        read_expect(16'h0700, 8'h00, "unmapped block");
        read_expect(SYS + 16'd6, 8'h00, "unmapped offset");
        report_test("system registers and reset state");

        for (int r = 0; r < 2; r++) begin
            draw_bits(8, rnd);
            draw_bits(8, rnd_b);
            // Cover both values of the reference select bit
            rnd_b[7] = (r == 0);
            write_reg(CTRL, rnd[7:0]);
            write_reg(CTRL + 16'd1, rnd_b[7:0]);
            draw_bits(4, rnd_c);
            i_gpio_sense = rnd_c[3:0];
            read_expect(CTRL, {rnd[7:4], rnd_c[3:0]}, "control low byte");
            i_gpio_sense = ~rnd_c[3:0];
            read_expect(CTRL, {rnd[7:4], ~rnd_c[3:0]}, "control low byte");
            read_expect(CTRL + 16'd1, rnd_b[7:0], "control high byte");
        end
        report_test("board control");

        read_expect(PULSE, daq_pkg::PULSE_VERSION, "pulser version");
        for (int t = 0; t < 4; t++) begin
            draw_bits(4, rnd);
            pulse_delay_exp = int'(rnd);
            draw_bits(3, rnd);
            pulse_width_exp = (t == 1) ? 0 : int'(rnd);
            write_reg(PULSE + PULSE_DELAY, 8'(pulse_delay_exp));
            write_reg(PULSE + PULSE_WIDTH, 8'(pulse_width_exp));
            write_reg(PULSE + PULSE_START, 8'h00);
            if (t == 3) begin
                // Restart while the first pulse may still be running
                next_cycles(2);
                write_reg(PULSE + PULSE_START, 8'h00);
            end
            while (!pulse_done_exp) next_cycles(1);
            read_expect(PULSE + PULSE_DONE, 8'h01, "pulse done");
            write_reg(PULSE + PULSE_SOFT_RST, 8'h00);
            read_expect(PULSE + PULSE_DONE, 8'h00, "done after soft reset");
        end
        report_test("reset pulse timing");

        write_reg(CTRL + CTRL_HOLD, 8'h01);
        next_cycles(5);
        read_expect(CTRL + CTRL_HOLD, 8'h01, "chip reset hold");
        write_reg(CTRL + CTRL_HOLD, 8'h00);
        next_cycles(3);
        report_test("chip reset hold");

        i_arb_ready = 1'b1;
        for (int c = 0; c < 40; c++) begin
            draw_bits(N, rnd);
            drive_streams(rnd[N-1:0]);
            next_cycles(1);
        end
        for (int c = 0; c < 6; c++) begin
            drive_streams('1);
            next_cycles(1);
        end
        report_test("arbiter fairness");

        for (int k = 0; k < 16; k++) begin
            draw_bits(1, rnd);
            i_arb_ready = rnd[0];
            draw_bits(2, rnd_b);
            repeat (rnd_b[1:0] + 1) begin
                draw_bits(N, rnd);
                drive_streams(rnd[N-1:0]);
                next_cycles(1);
            end
        end
        i_arb_ready = 1'b1;
        for (int c = 0; c < 4; c++) begin
            drive_streams('1);
            next_cycles(1);
        end
        i_arb_ready = 1'b0;
        i_stream_valid = '0;
        next_cycles(2);
        report_test("back-pressure");

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/board_control.sv
module board_control (
    input  logic                                  i_bus_clk,
    input  logic                                  i_bus_rst,
    input  logic                                  i_rd,
    input  logic                                  i_wr,
    input  logic [daq_pkg::LOCAL_ADDR_WIDTH-1:0]  i_add,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_wdata,
    input  logic [daq_pkg::SENSE_WIDTH-1:0]       i_gpio_sense,
    output logic [daq_pkg::DBUS_WIDTH-1:0]        o_rdata,
    output logic [daq_pkg::LEMO_MUX_WIDTH-1:0]    o_lemo_mux,
    output logic [daq_pkg::NTC_MUX_WIDTH-1:0]     o_ntc_mux,
    output logic                                  o_mgt_ref_sel,
    output logic                                  o_chip_rst_hold
);

    daq_pkg::ctrl_word_t ctrl_q;
    daq_pkg::ctrl_word_t ctrl_next;
    daq_pkg::ctrl_word_t ctrl_view;
    logic                hold_q;

    always_comb begin
        ctrl_next = ctrl_q;
        if (i_wr && i_add == 0) ctrl_next.bytes[0] = i_wdata;
        if (i_wr && i_add == 1) ctrl_next.bytes[1] = i_wdata;
        // Sense bits are board inputs, nothing is stored there
        ctrl_next.fields.sense = '0;
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            ctrl_q <= '0;
            hold_q <= 1'b0;
        end else begin
            ctrl_q <= ctrl_next;
            if (i_wr && i_add == 2) hold_q <= i_wdata[0];
        end
    end

    // Readback shows live sense inputs
    always_comb begin
        ctrl_view = ctrl_q;
        ctrl_view.fields.sense = i_gpio_sense;
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_rd) begin
            case (i_add)
                0: o_rdata <= ctrl_view.bytes[0];
                1: o_rdata <= ctrl_view.bytes[1];
                2: o_rdata <= {{(daq_pkg::DBUS_WIDTH-1){1'b0}}, hold_q};
                default: o_rdata <= '0;
            endcase
        end
    end

    assign o_lemo_mux      = ctrl_q.fields.lemo_mux;
    assign o_ntc_mux       = ctrl_q.fields.ntc_mux;
    // Stored 0 selects the internal reference clock
    assign o_mgt_ref_sel   = ~ctrl_q.fields.ref_sel;
    assign o_chip_rst_hold = hold_q;

endmodule

//--- verilog/bus_decoder.sv
module bus_decoder (
    input  logic                                  i_bus_clk,
    input  logic                                  i_bus_rst,
    input  logic [daq_pkg::ABUS_WIDTH-1:0]        i_bus_add,
    input  logic                                  i_bus_rd,
    input  logic                                  i_bus_wr,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_sys_rdata,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_ctrl_rdata,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_pulse_rdata,
    output logic                                  o_sys_rd,
    output logic                                  o_sys_wr,
    output logic                                  o_ctrl_rd,
    output logic                                  o_ctrl_wr,
    output logic                                  o_pulse_rd,
    output logic                                  o_pulse_wr,
    output logic [daq_pkg::LOCAL_ADDR_WIDTH-1:0]  o_local_add,
    output logic [daq_pkg::DBUS_WIDTH-1:0]        o_bus_data
);

    localparam int PAGE_LSB = daq_pkg::LOCAL_ADDR_WIDTH;
    localparam int PAGE_MSB = daq_pkg::ABUS_WIDTH - 1;

    logic       sys_hit;
    logic       ctrl_hit;
    logic       pulse_hit;
    logic [2:0] rd_sel_q;

    // Block select from the page bits above the local offset
    assign sys_hit   = i_bus_add[PAGE_MSB:PAGE_LSB] == daq_pkg::SYS_BASEADDR[PAGE_MSB:PAGE_LSB];
    assign ctrl_hit  = i_bus_add[PAGE_MSB:PAGE_LSB] == daq_pkg::CTRL_BASEADDR[PAGE_MSB:PAGE_LSB];
    assign pulse_hit =
        i_bus_add[PAGE_MSB:PAGE_LSB] == daq_pkg::PULSE_RST_BASEADDR[PAGE_MSB:PAGE_LSB];

    assign o_sys_rd   = i_bus_rd & sys_hit;
    assign o_sys_wr   = i_bus_wr & sys_hit;
    assign o_ctrl_rd  = i_bus_rd & ctrl_hit;
    assign o_ctrl_wr  = i_bus_wr & ctrl_hit;
    assign o_pulse_rd = i_bus_rd & pulse_hit;
    assign o_pulse_wr = i_bus_wr & pulse_hit;

    assign o_local_add = i_bus_add[PAGE_LSB-1:0];

    // Remember which block answers the read in the next cycle
    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            rd_sel_q <= '0;
        end else begin
            rd_sel_q <= {o_pulse_rd, o_ctrl_rd, o_sys_rd};
        end
    end

    always_comb begin
        o_bus_data = '0;
        if (rd_sel_q[0]) o_bus_data = i_sys_rdata;
        if (rd_sel_q[1]) o_bus_data = i_ctrl_rdata;
        if (rd_sel_q[2]) o_bus_data = i_pulse_rdata;
    end

    // Bus master must never issue rd and wr together, and pages never overlap
    assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        $onehot0({o_sys_rd, o_sys_wr, o_ctrl_rd, o_ctrl_wr, o_pulse_rd, o_pulse_wr}));

endmodule

//--- verilog/daq_core.sv
module daq_core (
    input  logic                                                  i_bus_clk,
    input  logic                                                  i_bus_rst,
    input  logic [daq_pkg::ABUS_WIDTH-1:0]                        i_bus_add,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]                        i_bus_data,
    input  logic                                                  i_bus_rd,
    input  logic                                                  i_bus_wr,
    output logic [daq_pkg::DBUS_WIDTH-1:0]                        o_bus_data,
    input  logic [daq_pkg::SENSE_WIDTH-1:0]                       i_gpio_sense,
    output logic [daq_pkg::LEMO_MUX_WIDTH-1:0]                    o_lemo_mux,
    output logic [daq_pkg::NTC_MUX_WIDTH-1:0]                     o_ntc_mux,
    output logic                                                  o_mgt_ref_sel,
    output logic                                                  o_resetb_ext,
    input  logic [daq_pkg::N_STREAMS-1:0]                         i_stream_valid,
    input  logic [daq_pkg::N_STREAMS*daq_pkg::STREAM_WIDTH-1:0]   i_stream_data,
    output logic [daq_pkg::N_STREAMS-1:0]                         o_stream_read,
    input  logic                                                  i_arb_ready,
    output logic                                                  o_arb_write,
    output logic [daq_pkg::STREAM_WIDTH-1:0]                      o_arb_data
);

    logic                                 sys_rd;
    logic                                 sys_wr;
    logic                                 ctrl_rd;
    logic                                 ctrl_wr;
    logic                                 pulse_rd;
    logic                                 pulse_wr;
    logic [daq_pkg::LOCAL_ADDR_WIDTH-1:0] local_add;
    logic [daq_pkg::DBUS_WIDTH-1:0]       sys_rdata;
    logic [daq_pkg::DBUS_WIDTH-1:0]       ctrl_rdata;
    logic [daq_pkg::DBUS_WIDTH-1:0]       pulse_rdata;
    logic                                 chip_rst_hold;
    logic                                 pulse_start;
    logic                                 pulse_soft_rst;
    logic [daq_pkg::PULSE_CNT_WIDTH-1:0]  pulse_delay;
    logic [daq_pkg::PULSE_CNT_WIDTH-1:0]  pulse_width;
    logic                                 rst_pulse;
    logic                                 pulse_done;

    bus_decoder bus_decoder_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_bus_add(i_bus_add),
        .i_bus_rd(i_bus_rd), .i_bus_wr(i_bus_wr),
        .i_sys_rdata(sys_rdata), .i_ctrl_rdata(ctrl_rdata), .i_pulse_rdata(pulse_rdata),
        .o_sys_rd(sys_rd), .o_sys_wr(sys_wr), .o_ctrl_rd(ctrl_rd), .o_ctrl_wr(ctrl_wr),
        .o_pulse_rd(pulse_rd), .o_pulse_wr(pulse_wr),
        .o_local_add(local_add), .o_bus_data(o_bus_data)
    );

    system_regs system_regs_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_rd(sys_rd), .i_wr(sys_wr),
        .i_add(local_add), .i_wdata(i_bus_data), .o_rdata(sys_rdata)
    );

    board_control board_control_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_rd(ctrl_rd), .i_wr(ctrl_wr),
        .i_add(local_add), .i_wdata(i_bus_data), .i_gpio_sense(i_gpio_sense),
        .o_rdata(ctrl_rdata), .o_lemo_mux(o_lemo_mux), .o_ntc_mux(o_ntc_mux),
        .o_mgt_ref_sel(o_mgt_ref_sel), .o_chip_rst_hold(chip_rst_hold)
    );

    pulse_regs pulse_regs_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_rd(pulse_rd), .i_wr(pulse_wr),
        .i_add(local_add), .i_wdata(i_bus_data), .i_done(pulse_done),
        .o_rdata(pulse_rdata), .o_start(pulse_start), .o_soft_rst(pulse_soft_rst),
        .o_delay(pulse_delay), .o_width(pulse_width)
    );

    pulse_core pulse_core_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_soft_rst(pulse_soft_rst),
        .i_start(pulse_start), .i_delay(pulse_delay), .i_width(pulse_width),
        .o_pulse(rst_pulse), .o_done(pulse_done)
    );

    // Chip reset is active low
    assign o_resetb_ext = ~(rst_pulse | chip_rst_hold);

    readout_arbiter readout_arbiter_i (
        .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
        .i_stream_valid(i_stream_valid), .i_stream_data(i_stream_data),
        .i_arb_ready(i_arb_ready), .o_stream_read(o_stream_read),
        .o_arb_write(o_arb_write), .o_arb_data(o_arb_data)
    );

endmodule

//--- verilog/daq_pkg.sv
package daq_pkg;

    // Local bus
    localparam int ABUS_WIDTH = 16;
    localparam int DBUS_WIDTH = 8;
    localparam int LOCAL_ADDR_WIDTH = 8;

    // Address map, every block spans 0x100
    localparam logic [ABUS_WIDTH-1:0] SYS_BASEADDR = 16'h0300;
    localparam logic [ABUS_WIDTH-1:0] PULSE_RST_BASEADDR = 16'h0400;
    localparam logic [ABUS_WIDTH-1:0] CTRL_BASEADDR = 16'h0500;

    // Firmware identification
    localparam logic [DBUS_WIDTH-1:0] VERSION = 8'd1;
    localparam logic [DBUS_WIDTH-1:0] VERSION_MINOR = 8'd0;
    localparam logic [DBUS_WIDTH-1:0] VERSION_MAJOR = 8'd0;
    localparam logic [DBUS_WIDTH-1:0] BOARD_ID = 8'd0;
    localparam logic [DBUS_WIDTH-1:0] PULSE_VERSION = 8'd3;

    // Readout merge
    localparam int N_STREAMS = 3;
    localparam int STREAM_WIDTH = 32;
    localparam int ARB_PTR_WIDTH = $clog2(N_STREAMS);

    // Board control fields
    localparam int SENSE_WIDTH = 4;
    localparam int NTC_MUX_WIDTH = 3;
    localparam int LEMO_MUX_WIDTH = 8;

    localparam int PULSE_CNT_WIDTH = 8;

    // Board control word, seen as two bus bytes or as fields
    typedef union packed {
        logic [1:0][DBUS_WIDTH-1:0] bytes;
        struct packed {
            logic                      ref_sel;
            logic [LEMO_MUX_WIDTH-1:0] lemo_mux;
            logic [NTC_MUX_WIDTH-1:0]  ntc_mux;
            logic [SENSE_WIDTH-1:0]    sense;
        } fields;
    } ctrl_word_t;

endpackage

//--- verilog/pulse_core.sv
module pulse_core (
    input  logic                                  i_bus_clk,
    input  logic                                  i_bus_rst,
    input  logic                                  i_soft_rst,
    input  logic                                  i_start,
    input  logic [daq_pkg::PULSE_CNT_WIDTH-1:0]   i_delay,
    input  logic [daq_pkg::PULSE_CNT_WIDTH-1:0]   i_width,
    output logic                                  o_pulse,
    output logic                                  o_done
);

    localparam int CW = daq_pkg::PULSE_CNT_WIDTH;

    logic          run_q;
    logic [CW:0]   cnt_q;
    logic [CW:0]   cnt_next;
    logic [CW-1:0] dly_q;
    logic [CW-1:0] wid_q;
    logic [CW-1:0] dly;
    logic [CW:0]   stop;
    logic [CW-1:0] len_q;

    // Cycle number after start, settings taken at the start edge
    assign cnt_next = i_start ? (CW+1)'(1) : cnt_q + 1'b1;
    assign dly      = i_start ? i_delay : dly_q;
    assign stop     = i_start ? {1'b0, i_delay} + {1'b0, i_width}
                              : {1'b0, dly_q} + {1'b0, wid_q};

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst || i_soft_rst) begin
            run_q   <= 1'b0;
            o_done  <= 1'b0;
            o_pulse <= 1'b0;
        end else if (i_start || run_q) begin
            // Done appears the cycle after the last pulse cycle
            run_q   <= cnt_next <= stop;
            o_done  <= cnt_next > stop;
            o_pulse <= cnt_next > {1'b0, dly} && cnt_next <= stop;
        end
    end

    always_ff @(posedge i_bus_clk) begin
        cnt_q <= cnt_next;
        if (i_start) begin
            dly_q <= i_delay;
            wid_q <= i_width;
        end
    end

    // Pulse cycles since the last start
    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst || i_start) begin
            len_q <= '0;
        end else if (o_pulse) begin
            len_q <= len_q + 1'b1;
        end
    end

    assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        o_pulse |-> len_q < wid_q);

endmodule

//--- verilog/pulse_regs.sv
module pulse_regs (
    input  logic                                  i_bus_clk,
    input  logic                                  i_bus_rst,
    input  logic                                  i_rd,
    input  logic                                  i_wr,
    input  logic [daq_pkg::LOCAL_ADDR_WIDTH-1:0]  i_add,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_wdata,
    input  logic                                  i_done,
    output logic [daq_pkg::DBUS_WIDTH-1:0]        o_rdata,
    output logic                                  o_start,
    output logic                                  o_soft_rst,
    output logic [daq_pkg::PULSE_CNT_WIDTH-1:0]   o_delay,
    output logic [daq_pkg::PULSE_CNT_WIDTH-1:0]   o_width
);

    logic [daq_pkg::PULSE_CNT_WIDTH-1:0] delay_q;
    logic [daq_pkg::PULSE_CNT_WIDTH-1:0] width_q;

    // Command strobes, write data ignored
    assign o_soft_rst = i_wr && i_add == 0;
    assign o_start    = i_wr && i_add == 1;

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            delay_q <= '0;
            width_q <= '0;
        end else if (i_wr) begin
            case (i_add)
                3: delay_q <= i_wdata;
                4: width_q <= i_wdata;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_rd) begin
            case (i_add)
                0: o_rdata <= daq_pkg::PULSE_VERSION;
                2: o_rdata <= {{(daq_pkg::DBUS_WIDTH-1){1'b0}}, i_done};
                3: o_rdata <= delay_q;
                4: o_rdata <= width_q;
                default: o_rdata <= '0;
            endcase
        end
    end

    assign o_delay = delay_q;
    assign o_width = width_q;

endmodule

//--- verilog/readout_arbiter.sv
module readout_arbiter (
    input  logic                                                  i_bus_clk,
    input  logic                                                  i_bus_rst,
    input  logic [daq_pkg::N_STREAMS-1:0]                         i_stream_valid,
    input  logic [daq_pkg::N_STREAMS*daq_pkg::STREAM_WIDTH-1:0]   i_stream_data,
    input  logic                                                  i_arb_ready,
    output logic [daq_pkg::N_STREAMS-1:0]                         o_stream_read,
    output logic                                                  o_arb_write,
    output logic [daq_pkg::STREAM_WIDTH-1:0]                      o_arb_data
);

    localparam int N  = daq_pkg::N_STREAMS;
    localparam int PW = daq_pkg::ARB_PTR_WIDTH;

    logic [PW-1:0] last_q;
    logic [PW-1:0] sel;
    logic          found;

    // Search starts one past the last granted stream
    always_comb begin
        int idx;
        o_stream_read = '0;
        sel           = last_q;
        found         = 1'b0;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last_q) + k) % N;
            if (!found && i_arb_ready && i_stream_valid[idx]) begin
                found              = 1'b1;
                sel                = PW'(idx);
                o_stream_read[idx] = 1'b1;
            end
        end
    end

    assign o_arb_write = found;
    assign o_arb_data  = i_stream_data[sel*daq_pkg::STREAM_WIDTH +: daq_pkg::STREAM_WIDTH];

    // Pointer holds under back-pressure
    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            // First grant after reset goes to stream 0
            last_q <= PW'(N - 1);
        end else if (found) begin
            last_q <= sel;
        end
    end

    assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        $onehot0(o_stream_read));

    assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        (o_stream_read & ~i_stream_valid) == '0);

    assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        o_arb_write |-> i_arb_ready);

endmodule

//--- verilog/system_regs.sv
module system_regs (
    input  logic                                  i_bus_clk,
    input  logic                                  i_bus_rst,
    input  logic                                  i_rd,
    input  logic                                  i_wr,
    input  logic [daq_pkg::LOCAL_ADDR_WIDTH-1:0]  i_add,
    input  logic [daq_pkg::DBUS_WIDTH-1:0]        i_wdata,
    output logic [daq_pkg::DBUS_WIDTH-1:0]        o_rdata
);

    logic clk_configured_q;

    // Set by software once the reference clock is programmed
    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            clk_configured_q <= 1'b0;
        end else if (i_wr) begin
            case (i_add)
                5: clk_configured_q <= i_wdata[0];
                default: begin
                end
            endcase
        end
    end

    // Read byte for the decoder
    always_ff @(posedge i_bus_clk) begin
        if (i_rd) begin
            case (i_add)
                0: o_rdata <= daq_pkg::VERSION;
                1: o_rdata <= daq_pkg::VERSION_MINOR;
                2: o_rdata <= daq_pkg::VERSION_MAJOR;
                3: o_rdata <= daq_pkg::BOARD_ID;
                4: o_rdata <= {{(daq_pkg::DBUS_WIDTH-1){1'b0}}, clk_configured_q};
                default: o_rdata <= '0;
            endcase
        end
    end

endmodule
